/* src/gmac_pkg.sv */
package gmac_pkg;

    // Field widths shared by the interfaces
    localparam int mac_bits = 48;
    localparam int ip_bits = 32;
    localparam int port_bits = 16;
    localparam int word_bits = 32;

    // Fabric defaults loaded on reset
    localparam logic [mac_bits-1:0] fabric_mac = 48'hffff_ffff_ffff;
    // 192.168.5.200
    localparam logic [ip_bits-1:0] fabric_ip = 32'hc0a8_05c8;
    localparam logic [ip_bits-1:0] fabric_netmask = 32'hffff_ff00;
    localparam logic [ip_bits-1:0] fabric_gateway = 32'h0000_0001;
    localparam logic [port_bits-1:0] fabric_port = 16'd10000;
    localparam logic fabric_enable_on_start = 1'b0;

    // ARP cache geometry
    localparam int arp_addr_bits = 9;
    localparam int arp_words = 1 << arp_addr_bits;

    // Rate measurement window in aximm_clk cycles
    localparam int rate_window = 256;
    localparam int rate_window_bits = $clog2(rate_window);

    // Read-only identity words
    localparam logic [word_bits-1:0] core_type_word = 32'h0010_0064;
    localparam logic [word_bits-1:0] word_size_bytes = 32'd64;
    localparam logic [word_bits-1:0] buffer_max_bytes = 32'd2048;

endpackage

/* src/gmac_cfg_if.sv */
`timescale 1ns/1ps

interface gmac_cfg_if;

    logic [gmac_pkg::mac_bits-1:0]  mac_address;
    logic [gmac_pkg::ip_bits-1:0]   local_ip;
    logic [gmac_pkg::ip_bits-1:0]   local_netmask;
    logic [gmac_pkg::ip_bits-1:0]   gateway_ip;
    logic [gmac_pkg::ip_bits-1:0]   multicast_ip;
    logic [gmac_pkg::ip_bits-1:0]   multicast_mask;
    logic [gmac_pkg::port_bits-1:0] udp_port;
    logic [gmac_pkg::word_bits-1:0] core_ctrl;

    // Register bank side
    modport source (
        output mac_address, local_ip, local_netmask, gateway_ip,
        output multicast_ip, multicast_mask, udp_port, core_ctrl
    );

    // Consumers of the shadowed configuration
    modport sink (
        input mac_address, local_ip, local_netmask, gateway_ip,
        input multicast_ip, multicast_mask, udp_port, core_ctrl
    );

endinterface

/* src/gmac_arp_if.sv */
`timescale 1ns/1ps

interface gmac_arp_if;

    // Only bit 0 of the enable words is meaningful
    logic [gmac_pkg::word_bits-1:0] write_enable;
    logic [gmac_pkg::word_bits-1:0] write_data;
    logic [gmac_pkg::word_bits-1:0] write_address;
    logic [gmac_pkg::word_bits-1:0] read_enable;
    logic [gmac_pkg::word_bits-1:0] read_address;

    modport source (
        output write_enable, write_data, write_address,
        output read_enable, read_address
    );

    modport sink (
        input write_enable, write_data, write_address,
        input read_enable, read_address
    );

endinterface

/* src/gmac_reg_shadow.sv */
`timescale 1ns/1ps

module gmac_reg_shadow (
    input  logic        aximm_clk,
    input  logic        gmac_reg_count_reset_we,

    input  logic [31:0] gmac_reg_mac_address_h,
    input  logic [31:0] gmac_reg_mac_address_l,
    input  logic [31:0] gmac_reg_local_ip_address,
    input  logic [31:0] gmac_reg_local_ip_netmask,
    input  logic [31:0] gmac_reg_gateway_ip_address,
    input  logic [31:0] gmac_reg_multicast_ip_address,
    input  logic [31:0] gmac_reg_multicast_ip_mask,
    input  logic [31:0] gmac_reg_udp_port,
    input  logic [31:0] gmac_reg_core_ctrl,
    input  logic        gmac_reg_mac_address_h_we,
    input  logic        gmac_reg_mac_address_l_we,
    input  logic        gmac_reg_local_ip_address_we,
    input  logic        gmac_reg_local_ip_netmask_we,
    input  logic        gmac_reg_gateway_ip_address_we,
    input  logic        gmac_reg_multicast_ip_address_we,
    input  logic        gmac_reg_multicast_ip_mask_we,
    input  logic        gmac_reg_udp_port_we,
    input  logic        gmac_reg_core_ctrl_we,

    input  logic [31:0] gmac_arp_cache_write_enable,
    input  logic [31:0] gmac_arp_cache_read_enable,
    input  logic [31:0] gmac_arp_cache_write_data,
    input  logic [31:0] gmac_arp_cache_write_address,
    input  logic [31:0] gmac_arp_cache_read_address,
    input  logic        gmac_arp_cache_write_enable_we,
    input  logic        gmac_arp_cache_read_enable_we,
    input  logic        gmac_arp_cache_write_data_we,
    input  logic        gmac_arp_cache_write_address_we,
    input  logic        gmac_arp_cache_read_address_we,

    gmac_cfg_if.source  cfg,
    gmac_arp_if.source  arp
);

    // MAC is split over two software words
    logic [15:0] mac_h_q;
    logic [31:0] mac_l_q;

    assign cfg.mac_address = {mac_h_q, mac_l_q};

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            mac_h_q <= gmac_pkg::fabric_mac[47:32];
            mac_l_q <= gmac_pkg::fabric_mac[31:0];
            cfg.local_ip <= gmac_pkg::fabric_ip;
            cfg.local_netmask <= gmac_pkg::fabric_netmask;
            cfg.gateway_ip <= gmac_pkg::fabric_gateway;
            cfg.multicast_ip <= '0;
            cfg.multicast_mask <= '0;
            cfg.udp_port <= gmac_pkg::fabric_port;
            cfg.core_ctrl <= {31'h0, gmac_pkg::fabric_enable_on_start};
        end else begin
            // Upper half of MAC high is not stored
            if (gmac_reg_mac_address_h_we)
                mac_h_q <= gmac_reg_mac_address_h[15:0];
            if (gmac_reg_mac_address_l_we)
                mac_l_q <= gmac_reg_mac_address_l;
            if (gmac_reg_local_ip_address_we)
                cfg.local_ip <= gmac_reg_local_ip_address;
            if (gmac_reg_local_ip_netmask_we)
                cfg.local_netmask <= gmac_reg_local_ip_netmask;
            if (gmac_reg_gateway_ip_address_we)
                cfg.gateway_ip <= gmac_reg_gateway_ip_address;
            if (gmac_reg_multicast_ip_address_we)
                cfg.multicast_ip <= gmac_reg_multicast_ip_address;
            if (gmac_reg_multicast_ip_mask_we)
                cfg.multicast_mask <= gmac_reg_multicast_ip_mask;
            if (gmac_reg_udp_port_we)
                cfg.udp_port <= gmac_reg_udp_port[15:0];
            if (gmac_reg_core_ctrl_we)
                cfg.core_ctrl <= gmac_reg_core_ctrl;
        end
    end

    // ARP access words clear to zero so no cache write is pending
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            arp.write_enable <= '0;
            arp.read_enable <= '0;
            arp.write_data <= '0;
            arp.write_address <= '0;
            arp.read_address <= '0;
        end else begin
            if (gmac_arp_cache_write_enable_we)
                arp.write_enable <= gmac_arp_cache_write_enable;
            if (gmac_arp_cache_read_enable_we)
                arp.read_enable <= gmac_arp_cache_read_enable;
            if (gmac_arp_cache_write_data_we)
                arp.write_data <= gmac_arp_cache_write_data;
            if (gmac_arp_cache_write_address_we)
                arp.write_address <= gmac_arp_cache_write_address;
            if (gmac_arp_cache_read_address_we)
                arp.read_address <= gmac_arp_cache_read_address;
        end
    end

    // Strobes are driven once reset is released
    strobes_known: assert property (
        @(posedge aximm_clk) disable iff (gmac_reg_count_reset_we)
        !$isunknown({gmac_reg_mac_address_h_we, gmac_reg_mac_address_l_we,
                     gmac_reg_local_ip_address_we, gmac_reg_local_ip_netmask_we,
                     gmac_reg_gateway_ip_address_we, gmac_reg_multicast_ip_address_we,
                     gmac_reg_multicast_ip_mask_we, gmac_reg_udp_port_we,
                     gmac_reg_core_ctrl_we, gmac_arp_cache_write_enable_we,
                     gmac_arp_cache_read_enable_we, gmac_arp_cache_write_data_we,
                     gmac_arp_cache_write_address_we, gmac_arp_cache_read_address_we})
    );

endmodule

/* src/gmac_arp_cache.sv */
`timescale 1ns/1ps

module gmac_arp_cache (
    input  logic        aximm_clk,
    input  logic        gmac_reg_count_reset_we,
    gmac_arp_if.sink    arp,
    output logic [31:0] read_data
);

    logic [31:0]                        mem [gmac_pkg::arp_words];
    logic                               write_enable_q;
    logic                               write_pulse;
    logic [gmac_pkg::arp_addr_bits-1:0] write_index;
    logic [gmac_pkg::arp_addr_bits-1:0] read_index;

    // A write fires on the rising edge of the enable bit
    assign write_pulse = arp.write_enable[0] & ~write_enable_q;

    // Addresses wrap modulo the cache depth
    assign write_index = arp.write_address[gmac_pkg::arp_addr_bits-1:0];
    assign read_index = arp.read_address[gmac_pkg::arp_addr_bits-1:0];

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we)
            write_enable_q <= 1'b0;
        else
            write_enable_q <= arp.write_enable[0];
    end

    always_ff @(posedge aximm_clk) begin
        if (write_pulse)
            mem[write_index] <= arp.write_data;
    end

    // Registered read port that holds while read enable is low
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we)
            read_data <= '0;
        else if (arp.read_enable[0])
            read_data <= mem[read_index];
    end

    // Written cells take defined data at a defined index
    write_fields_known: assert property (
        @(posedge aximm_clk) disable iff (gmac_reg_count_reset_we)
        write_pulse |-> !$isunknown({write_index, arp.write_data})
    );

endmodule

/* src/gmac_traffic_stats.sv */
`timescale 1ns/1ps

module gmac_traffic_stats (
    input  logic        aximm_clk,
    input  logic        gmac_reg_count_reset_we,
    gmac_cfg_if.sink    cfg,

    input  logic [3:0]  tx_valid,
    input  logic        tx_end_of_frame,
    input  logic        tx_overflow,
    input  logic        tx_almost_full,
    input  logic        rx_valid,
    input  logic        rx_end_of_frame,
    input  logic        rx_overrun,
    input  logic        rx_bad_frame,

    output logic [31:0] tx_packet_count,
    output logic [31:0] tx_valid_count,
    output logic [31:0] tx_packet_rate,
    output logic [31:0] tx_valid_rate,
    output logic [31:0] tx_overflow_count,
    output logic [31:0] tx_almost_full_count,
    output logic [31:0] rx_packet_count,
    output logic [31:0] rx_valid_count,
    output logic [31:0] rx_packet_rate,
    output logic [31:0] rx_valid_rate,
    output logic [31:0] rx_overflow_count,
    output logic [31:0] rx_almost_full_count,
    output logic [31:0] rx_bad_packet_count
);

    logic                                  count_en;
    logic                                  tx_any_valid;
    logic [7:0]                            event_hit;
    logic [3:0]                            rate_hit;
    logic [31:0]                           count_q [8];
    logic [31:0]                           tally_q [4];
    logic [31:0]                           rate_q [4];
    logic [gmac_pkg::rate_window_bits-1:0] window_q;
    logic                                  window_done;

    assign count_en = cfg.core_ctrl[0];
    assign tx_any_valid = |tx_valid;

    // Slot order: tx pkt, tx valid, tx ovf, tx afull, rx pkt, rx valid, rx overrun, rx bad
    assign event_hit = {
        rx_bad_frame & rx_end_of_frame,
        rx_overrun,
        rx_valid,
        rx_valid & rx_end_of_frame,
        tx_almost_full,
        tx_overflow,
        tx_any_valid,
        tx_any_valid & tx_end_of_frame
    };

    // Packet and valid events that also feed the rate tallies
    assign rate_hit = {event_hit[5], event_hit[4], event_hit[1], event_hit[0]};

    assign window_done = (window_q == gmac_pkg::rate_window_bits'(gmac_pkg::rate_window - 1));

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            window_q <= '0;
            for (int i = 0; i < 8; i++)
                count_q[i] <= '0;
            for (int i = 0; i < 4; i++) begin
                tally_q[i] <= '0;
                rate_q[i] <= '0;
            end
        end else begin
            window_q <= window_done ? '0 : window_q + 1'b1;
            // Saturate at all ones
            for (int i = 0; i < 8; i++) begin
                if (count_en && event_hit[i] && count_q[i] != '1)
                    count_q[i] <= count_q[i] + 1'b1;
            end
            // Last cycle of the window still counts toward it
            for (int i = 0; i < 4; i++) begin
                if (window_done) begin
                    rate_q[i] <= tally_q[i] + {31'h0, count_en & rate_hit[i]};
                    tally_q[i] <= '0;
                end else if (count_en && rate_hit[i]) begin
                    tally_q[i] <= tally_q[i] + 1'b1;
                end
            end
        end
    end

    assign tx_packet_count = count_q[0];
    assign tx_valid_count = count_q[1];
    assign tx_overflow_count = count_q[2];
    assign tx_almost_full_count = count_q[3];
    assign rx_packet_count = count_q[4];
    assign rx_valid_count = count_q[5];
    // Overrun is the only receive back-up indication
    assign rx_overflow_count = count_q[6];
    assign rx_almost_full_count = count_q[6];
    assign rx_bad_packet_count = count_q[7];

    assign tx_packet_rate = rate_q[0];
    assign tx_valid_rate = rate_q[1];
    assign rx_packet_rate = rate_q[2];
    assign rx_valid_rate = rate_q[3];

    tx_eof_with_valid: assert property (
        @(posedge aximm_clk) disable iff (gmac_reg_count_reset_we)
        tx_end_of_frame |-> tx_any_valid
    );

endmodule

/* src/gmac_ctrl_top.sv */
`timescale 1ns/1ps

module gmac_ctrl_top (
    input  logic        aximm_clk,
    input  logic        gmac_reg_count_reset_we,

    input  logic [31:0] gmac_reg_mac_address_h,
    input  logic [31:0] gmac_reg_mac_address_l,
    input  logic [31:0] gmac_reg_local_ip_address,
    input  logic [31:0] gmac_reg_local_ip_netmask,
    input  logic [31:0] gmac_reg_gateway_ip_address,
    input  logic [31:0] gmac_reg_multicast_ip_address,
    input  logic [31:0] gmac_reg_multicast_ip_mask,
    input  logic [31:0] gmac_reg_udp_port,
    input  logic [31:0] gmac_reg_core_ctrl,
    input  logic        gmac_reg_mac_address_h_we,
    input  logic        gmac_reg_mac_address_l_we,
    input  logic        gmac_reg_local_ip_address_we,
    input  logic        gmac_reg_local_ip_netmask_we,
    input  logic        gmac_reg_gateway_ip_address_we,
    input  logic        gmac_reg_multicast_ip_address_we,
    input  logic        gmac_reg_multicast_ip_mask_we,
    input  logic        gmac_reg_udp_port_we,
    input  logic        gmac_reg_core_ctrl_we,

    input  logic [31:0] gmac_arp_cache_write_enable,
    input  logic [31:0] gmac_arp_cache_read_enable,
    input  logic [31:0] gmac_arp_cache_write_data,
    input  logic [31:0] gmac_arp_cache_write_address,
    input  logic [31:0] gmac_arp_cache_read_address,
    input  logic        gmac_arp_cache_write_enable_we,
    input  logic        gmac_arp_cache_read_enable_we,
    input  logic        gmac_arp_cache_write_data_we,
    input  logic        gmac_arp_cache_write_address_we,
    input  logic        gmac_arp_cache_read_address_we,

    // Yellow block strobes
    input  logic [3:0]  tx_valid,
    input  logic        tx_end_of_frame,
    input  logic        tx_overflow,
    input  logic        tx_almost_full,
    input  logic        rx_valid,
    input  logic        rx_end_of_frame,
    input  logic        rx_overrun,
    input  logic        rx_bad_frame,

    output logic [31:0] gmac_reg_tx_packet_count,
    output logic [31:0] gmac_reg_tx_valid_count,
    output logic [31:0] gmac_reg_tx_packet_rate,
    output logic [31:0] gmac_reg_tx_valid_rate,
    output logic [31:0] gmac_reg_tx_overflow_count,
    output logic [31:0] gmac_reg_tx_almost_full_count,
    output logic [31:0] gmac_reg_rx_packet_count,
    output logic [31:0] gmac_reg_rx_valid_count,
    output logic [31:0] gmac_reg_rx_packet_rate,
    output logic [31:0] gmac_reg_rx_valid_rate,
    output logic [31:0] gmac_reg_rx_overflow_count,
    output logic [31:0] gmac_reg_rx_almost_full_count,
    output logic [31:0] gmac_reg_rx_bad_packet_count,
    output logic [31:0] gmac_arp_cache_read_data,

    output logic [31:0] gmac_reg_core_type,
    output logic [31:0] gmac_reg_arp_size,
    output logic [31:0] gmac_reg_word_size,
    output logic [31:0] gmac_reg_buffer_max_size,

    // Shadowed configuration for the Ethernet core
    output logic [47:0] cfg_mac_address,
    output logic [31:0] cfg_local_ip,
    output logic [31:0] cfg_local_netmask,
    output logic [31:0] cfg_gateway_ip,
    output logic [31:0] cfg_multicast_ip,
    output logic [31:0] cfg_multicast_mask,
    output logic [15:0] cfg_udp_port,
    output logic [31:0] cfg_core_ctrl
);

    gmac_cfg_if cfg_bus ();
    gmac_arp_if arp_bus ();

    // Register inputs share their names with the shadow bank ports
    gmac_reg_shadow u_gmac_reg_shadow (
        .cfg (cfg_bus.source),
        .arp (arp_bus.source),
        .*
    );

    gmac_arp_cache u_gmac_arp_cache (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .arp                     (arp_bus.sink),
        .read_data               (gmac_arp_cache_read_data)
    );

    gmac_traffic_stats u_gmac_traffic_stats (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .cfg                     (cfg_bus.sink),
        .tx_valid                (tx_valid),
        .tx_end_of_frame         (tx_end_of_frame),
        .tx_overflow             (tx_overflow),
        .tx_almost_full          (tx_almost_full),
        .rx_valid                (rx_valid),
        .rx_end_of_frame         (rx_end_of_frame),
        .rx_overrun              (rx_overrun),
        .rx_bad_frame            (rx_bad_frame),
        .tx_packet_count         (gmac_reg_tx_packet_count),
        .tx_valid_count          (gmac_reg_tx_valid_count),
        .tx_packet_rate          (gmac_reg_tx_packet_rate),
        .tx_valid_rate           (gmac_reg_tx_valid_rate),
        .tx_overflow_count       (gmac_reg_tx_overflow_count),
        .tx_almost_full_count    (gmac_reg_tx_almost_full_count),
        .rx_packet_count         (gmac_reg_rx_packet_count),
        .rx_valid_count          (gmac_reg_rx_valid_count),
        .rx_packet_rate          (gmac_reg_rx_packet_rate),
        .rx_valid_rate           (gmac_reg_rx_valid_rate),
        .rx_overflow_count       (gmac_reg_rx_overflow_count),
        .rx_almost_full_count    (gmac_reg_rx_almost_full_count),
        .rx_bad_packet_count     (gmac_reg_rx_bad_packet_count)
    );

    assign cfg_mac_address = cfg_bus.mac_address;
    assign cfg_local_ip = cfg_bus.local_ip;
    assign cfg_local_netmask = cfg_bus.local_netmask;
    assign cfg_gateway_ip = cfg_bus.gateway_ip;
    assign cfg_multicast_ip = cfg_bus.multicast_ip;
    assign cfg_multicast_mask = cfg_bus.multicast_mask;
    assign cfg_udp_port = cfg_bus.udp_port;
    assign cfg_core_ctrl = cfg_bus.core_ctrl;

    // Identity words read by software
    assign gmac_reg_core_type = gmac_pkg::core_type_word;
    assign gmac_reg_arp_size = 32'(gmac_pkg::arp_words);
    assign gmac_reg_word_size = gmac_pkg::word_size_bytes;
    assign gmac_reg_buffer_max_size = gmac_pkg::buffer_max_bytes;

endmodule

/* dv/tb_gmac_ctrl.sv */
`timescale 1ns/1ps

module tb_gmac_ctrl;

    localparam int clk_period = 20;
    localparam int reset_cycles = 16;
    localparam int trace_depth = 64;
    localparam int stat_count = 13;

    logic        aximm_clk;
    logic        gmac_reg_count_reset_we;
    // Shadow bank words first, then the five ARP access words
    logic [31:0] reg_data [14];
    logic [13:0] reg_we;
    // From bit 0: tx_valid[3:0], tx eof, tx ovf, tx afull, rx valid, rx eof, rx overrun, rx bad
    logic [10:0] traffic;

    wire [31:0] stat [stat_count];
    wire [31:0] gmac_arp_cache_read_data;
    wire [31:0] gmac_reg_core_type;
    wire [31:0] gmac_reg_arp_size;
    wire [31:0] gmac_reg_word_size;
    wire [31:0] gmac_reg_buffer_max_size;
    wire [47:0] cfg_mac_address;
    wire [31:0] cfg_local_ip;
    wire [31:0] cfg_local_netmask;
    wire [31:0] cfg_gateway_ip;
    wire [31:0] cfg_multicast_ip;
    wire [31:0] cfg_multicast_mask;
    wire [15:0] cfg_udp_port;
    wire [31:0] cfg_core_ctrl;

    logic [79:0] trace_mem [trace_depth];
    logic [63:0] exp_cfg [8];
    logic [31:0] model_stat [stat_count];
    logic [31:0] model_tally [stat_count];
    logic        model_enable;
    int          window_pos;
    logic [31:0] lcg_state;
    int          budget_cycles;
    int          check_count;
    int          error_count;

    string stat_names [stat_count] = '{
        "tx_packet_count", "tx_valid_count", "tx_packet_rate", "tx_valid_rate",
        "tx_overflow_count", "tx_almost_full_count", "rx_packet_count", "rx_valid_count",
        "rx_packet_rate", "rx_valid_rate", "rx_overflow_count", "rx_almost_full_count",
        "rx_bad_packet_count"
    };
    string out_names [13] = '{
        "cfg_mac_address", "cfg_local_ip", "cfg_local_netmask", "cfg_gateway_ip",
        "cfg_multicast_ip", "cfg_multicast_mask", "cfg_udp_port", "cfg_core_ctrl",
        "gmac_arp_cache_read_data", "gmac_reg_core_type", "gmac_reg_arp_size",
        "gmac_reg_word_size", "gmac_reg_buffer_max_size"
    };

    gmac_ctrl_top u_gmac_ctrl_top (
        .gmac_reg_mac_address_h           (reg_data[0]),
        .gmac_reg_mac_address_l           (reg_data[1]),
        .gmac_reg_local_ip_address        (reg_data[2]),
        .gmac_reg_local_ip_netmask        (reg_data[3]),
        .gmac_reg_gateway_ip_address      (reg_data[4]),
        .gmac_reg_multicast_ip_address    (reg_data[5]),
        .gmac_reg_multicast_ip_mask       (reg_data[6]),
        .gmac_reg_udp_port                (reg_data[7]),
        .gmac_reg_core_ctrl               (reg_data[8]),
        .gmac_reg_mac_address_h_we        (reg_we[0]),
        .gmac_reg_mac_address_l_we        (reg_we[1]),
        .gmac_reg_local_ip_address_we     (reg_we[2]),
        .gmac_reg_local_ip_netmask_we     (reg_we[3]),
        .gmac_reg_gateway_ip_address_we   (reg_we[4]),
        .gmac_reg_multicast_ip_address_we (reg_we[5]),
        .gmac_reg_multicast_ip_mask_we    (reg_we[6]),
        .gmac_reg_udp_port_we             (reg_we[7]),
        .gmac_reg_core_ctrl_we            (reg_we[8]),
        .gmac_arp_cache_write_enable      (reg_data[9]),
        .gmac_arp_cache_read_enable       (reg_data[10]),
        .gmac_arp_cache_write_data        (reg_data[11]),
        .gmac_arp_cache_write_address     (reg_data[12]),
        .gmac_arp_cache_read_address      (reg_data[13]),
        .gmac_arp_cache_write_enable_we   (reg_we[9]),
        .gmac_arp_cache_read_enable_we    (reg_we[10]),
        .gmac_arp_cache_write_data_we     (reg_we[11]),
        .gmac_arp_cache_write_address_we  (reg_we[12]),
        .gmac_arp_cache_read_address_we   (reg_we[13]),
        .tx_valid                         (traffic[3:0]),
        .tx_end_of_frame                  (traffic[4]),
        .tx_overflow                      (traffic[5]),
        .tx_almost_full                   (traffic[6]),
        .rx_valid                         (traffic[7]),
        .rx_end_of_frame                  (traffic[8]),
        .rx_overrun                       (traffic[9]),
        .rx_bad_frame                     (traffic[10]),
        .gmac_reg_tx_packet_count         (stat[0]),
        .gmac_reg_tx_valid_count          (stat[1]),
        .gmac_reg_tx_packet_rate          (stat[2]),
        .gmac_reg_tx_valid_rate           (stat[3]),
        .gmac_reg_tx_overflow_count       (stat[4]),
        .gmac_reg_tx_almost_full_count    (stat[5]),
        .gmac_reg_rx_packet_count         (stat[6]),
        .gmac_reg_rx_valid_count          (stat[7]),
        .gmac_reg_rx_packet_rate          (stat[8]),
        .gmac_reg_rx_valid_rate           (stat[9]),
        .gmac_reg_rx_overflow_count       (stat[10]),
        .gmac_reg_rx_almost_full_count    (stat[11]),
        .gmac_reg_rx_bad_packet_count     (stat[12]),
        .*
    );

    always #(clk_period / 2) aximm_clk = ~aximm_clk;

    // Linear congruential generator for idle gaps
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Event behind each statistic, by output order
    function automatic logic stat_event(input int idx, input logic [10:0] t);
        logic tx_any;
        tx_any = |t[3:0];
        case (idx)
            0, 2: return tx_any & t[4];
            1, 3: return tx_any;
            4: return t[5];
            5: return t[6];
            6, 8: return t[7] & t[8];
            7, 9: return t[7];
            10, 11: return t[9];
            default: return t[10] & t[8];
        endcase
    endfunction

    // Counter and rate model, updated on the same edges as the DUT
    always @(posedge aximm_clk) begin : counter_model
        logic hit;
        if (gmac_reg_count_reset_we) begin
            model_enable <= gmac_pkg::fabric_enable_on_start;
            window_pos <= 0;
            for (int i = 0; i < stat_count; i++) begin
                model_stat[i] <= '0;
                model_tally[i] <= '0;
            end
        end else begin
            if (reg_we[8])
                model_enable <= reg_data[8][0];
            window_pos <= (window_pos == gmac_pkg::rate_window - 1) ? 0 : window_pos + 1;
            for (int i = 0; i < stat_count; i++) begin
                hit = model_enable & stat_event(i, traffic);
                if (i != 2 && i != 3 && i != 8 && i != 9) begin
                    if (hit && model_stat[i] != 32'hffff_ffff)
                        model_stat[i] <= model_stat[i] + 1;
                end else if (window_pos == gmac_pkg::rate_window - 1) begin
                    model_stat[i] <= model_tally[i] + hit;
                    model_tally[i] <= '0;
                end else if (hit) begin
                    model_tally[i] <= model_tally[i] + 1;
                end
            end
        end
    end

    function automatic logic [63:0] observe(input int sel);
        case (sel)
            0: return cfg_mac_address;
            1: return cfg_local_ip;
            2: return cfg_local_netmask;
            3: return cfg_gateway_ip;
            4: return cfg_multicast_ip;
            5: return cfg_multicast_mask;
            6: return cfg_udp_port;
            7: return cfg_core_ctrl;
            8: return gmac_arp_cache_read_data;
            9: return gmac_reg_core_type;
            10: return gmac_reg_arp_size;
            11: return gmac_reg_word_size;
            12: return gmac_reg_buffer_max_size;
            default: return 'x;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge aximm_clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_config();
        for (int i = 0; i < 8; i++)
            check_value(out_names[i], observe(i), exp_cfg[i]);
    endtask

    task automatic load_defaults();
        exp_cfg[0] = gmac_pkg::fabric_mac;
        exp_cfg[1] = gmac_pkg::fabric_ip;
        exp_cfg[2] = gmac_pkg::fabric_netmask;
        exp_cfg[3] = gmac_pkg::fabric_gateway;
        exp_cfg[4] = '0;
        exp_cfg[5] = '0;
        exp_cfg[6] = gmac_pkg::fabric_port;
        exp_cfg[7] = gmac_pkg::fabric_enable_on_start;
    endtask

    task automatic apply_reset();
        gmac_reg_count_reset_we = 1'b1;
        repeat (reset_cycles) next_cycle();
        gmac_reg_count_reset_we = 1'b0;
        load_defaults();
        check_config();
    endtask

    task automatic write_register(input int sel, input logic [31:0] value);
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap = (lcg_state >> 16) % 3;
        repeat (gap) next_cycle();
        reg_data[sel] = value;
        reg_we[sel] = 1'b1;
        // MAC high and UDP port keep their low 16 bits
        if (sel == 0)
            exp_cfg[0][47:32] = value[15:0];
        else if (sel == 1)
            exp_cfg[0][31:0] = value;
        else if (sel == 7)
            exp_cfg[6] = {48'h0, value[15:0]};
        else if (sel < 9)
            exp_cfg[sel - 1] = {32'h0, value};
        next_cycle();
        reg_we[sel] = 1'b0;
        check_config();
    endtask

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * clk_period);
        $display("Watchdog expired before the trace finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [3:0]  op;
        logic [11:0] sel;
        logic [63:0] value;
        int          line_count;
        int          budget;
        aximm_clk = 1'b0;
        gmac_reg_count_reset_we = 1'b1;
        reg_we = '0;
        traffic = '0;
        lcg_state = 32'hc50d;
        for (int i = 0; i < 14; i++)
            reg_data[i] = '0;
        for (int i = 0; i < trace_depth; i++)
            trace_mem[i] = '0;
        $readmemh("dv/gmac_ctrl_trace.txt", trace_mem);

        // Budget covers each line, its idle or traffic cycles and the longest gap
        line_count = 0;
        budget = 2 * reset_cycles + 100;
        while (line_count < trace_depth && trace_mem[line_count][79:76] != 4'h0) begin
            op = trace_mem[line_count][79:76];
            budget += 3;
            if (op == 4'h2 || op == 4'h3)
                budget += int'(trace_mem[line_count][31:0]);
            if (op == 4'h6)
                budget += reset_cycles;
            line_count++;
        end
        budget_cycles = budget;
        if (line_count == 0) begin
            $display("Trace file dv/gmac_ctrl_trace.txt is missing or empty");
            error_count++;
        end

        apply_reset();
        for (int i = 0; i < line_count; i++) begin
            op = trace_mem[i][79:76];
            sel = trace_mem[i][75:64];
            value = trace_mem[i][63:0];
            case (op)
                4'h1: write_register(sel, value[31:0]);
                4'h2: begin
                    traffic = sel[10:0];
                    repeat (value) next_cycle();
                    traffic = '0;
                end
                4'h3: repeat (value) next_cycle();
                4'h4: check_value(out_names[sel], observe(sel), value);
                4'h5: begin
                    for (int k = 0; k < stat_count; k++)
                        check_value(stat_names[k], stat[k], model_stat[k]);
                end
                4'h6: apply_reset();
                default: begin
                    $display("Trace line %0d has an unknown opcode %0h", i, op);
                    error_count++;
                end
            endcase
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* dv/gmac_ctrl_trace.txt */
// Columns op_sel_value in hex: op 1 write register sel, 2 traffic bits sel for value cycles,
// 3 idle value cycles, 4 expect output sel equals value, 5 compare statistics, 6 reset
5_000_0000_0000_0000_0000
4_008_0000_0000_0000_0000
4_009_0000_0000_0010_0064
4_00a_0000_0000_0000_0200
4_00b_0000_0000_0000_0040
4_00c_0000_0000_0000_0800
// Configuration words, MAC high and UDP port keep 16 bits
1_000_0000_0000_abcd_1234
4_000_0000_1234_ffff_ffff
1_001_0000_0000_0011_2233
4_000_0000_1234_0011_2233
1_002_0000_0000_0a00_0002
1_003_0000_0000_ffff_f000
1_004_0000_0000_0a00_00fe
1_005_0000_0000_e000_00fb
1_006_0000_0000_ffff_ff00
1_007_0000_0000_0001_c350
4_006_0000_0000_0000_c350
// Traffic is ignored while counting is off
2_7ff_0000_0000_0000_0014
5_000_0000_0000_0000_0000
// ARP writes, the second address wraps onto cell 3
1_00b_0000_0000_0a0b_0c0d
1_00c_0000_0000_0000_0005
1_009_0000_0000_0000_0001
1_009_0000_0000_0000_0000
1_00b_0000_0000_cafe_0203
1_00c_0000_0000_0000_0203
1_009_0000_0000_0000_0001
1_009_0000_0000_0000_0000
// Reads land two cycles after the address strobe
1_00a_0000_0000_0000_0001
1_00d_0000_0000_0000_0003
3_000_0000_0000_0000_0001
4_008_0000_0000_cafe_0203
1_00d_0000_0000_0000_0205
3_000_0000_0000_0000_0001
4_008_0000_0000_0a0b_0c0d
// Read enable off, data holds
1_00a_0000_0000_0000_0000
1_00d_0000_0000_0000_0003
3_000_0000_0000_0000_0002
4_008_0000_0000_0a0b_0c0d
// Counting on, traffic spans more than one rate window
1_008_0000_0000_0000_0001
2_191_0000_0000_0000_0030
2_682_0000_0000_0000_0020
2_560_0000_0000_0000_0012
2_798_0000_0000_0000_0100
5_000_0000_0000_0000_0000
3_000_0000_0000_0000_0120
5_000_0000_0000_0000_0000
// Second reset restores defaults and clears statistics
6_000_0000_0000_0000_0000
5_000_0000_0000_0000_0000
4_008_0000_0000_0000_0000

/* flist.f */
src/gmac_pkg.sv
src/gmac_cfg_if.sv
src/gmac_arp_if.sv
src/gmac_reg_shadow.sv
src/gmac_arp_cache.sv
src/gmac_traffic_stats.sv
src/gmac_ctrl_top.sv
dv/tb_gmac_ctrl.sv

/* Bender.yml */
package:
  name: gmac_ctrl

sources:
  - src/gmac_pkg.sv
  - src/gmac_cfg_if.sv
  - src/gmac_arp_if.sv
  - src/gmac_reg_shadow.sv
  - src/gmac_arp_cache.sv
  - src/gmac_traffic_stats.sv
  - src/gmac_ctrl_top.sv
  - target: test
    files:
      - dv/tb_gmac_ctrl.sv
